// ==== hdl/camera_capture.sv ====
`include "camera_consts.svh"

module camera_capture (
   input  logic                      clk_camera,
   input  logic                      rst_in,
   input  logic [`CAMERA_BYTE_W-1:0] cam_data,
   input  logic                      cam_pclk,
   input  logic                      cam_hsync,
   input  logic                      cam_vsync,
   output logic                      hsync,
   output logic                      vsync,
   output logic                      byte_valid,
   output logic                      pixel_valid,
   output camera_pkg::pixel_t        pixel
);

   // two-flop synchronizer stages for the camera pins
   logic [`CAMERA_BYTE_W-1:0] data_s0;
   logic [`CAMERA_BYTE_W-1:0] data_s1;
   logic                      pclk_s0;
   logic                      pclk_s1;
   logic                      hs_s0;
   logic                      hs_s1;
   logic                      vs_s0;
   logic                      vs_s1;

   logic pclk_prev;
   logic pclk_rise;
   logic byte_take;

   // low on the first byte of a pixel, high on the second
   logic phase;

   always_ff @(posedge clk_camera) begin
      data_s0 <= cam_data;
      pclk_s0 <= cam_pclk;
      hs_s0   <= cam_hsync;
      vs_s0   <= cam_vsync;
      data_s1 <= data_s0;
      pclk_s1 <= pclk_s0;
      hs_s1   <= hs_s0;
      vs_s1   <= vs_s0;
   end

   assign pclk_rise = pclk_s1 && !pclk_prev;

   // bytes only count inside the active part of a line
   assign byte_take = pclk_rise && hs_s1;

   always_ff @(posedge clk_camera) begin
      if (rst_in) begin
         pclk_prev   <= 1'b0;
         phase       <= 1'b0;
         byte_valid  <= 1'b0;
         pixel_valid <= 1'b0;
         hsync       <= 1'b0;
         vsync       <= 1'b0;
      end else begin
         pclk_prev   <= pclk_s1;
         hsync       <= hs_s1;
         vsync       <= vs_s1;
         byte_valid  <= byte_take;
         pixel_valid <= byte_take && phase;
         if (!hs_s1) begin
            phase <= 1'b0;
         end else if (pclk_rise) begin
            phase <= !phase;
         end
      end
   end

   // first byte of a pair fills the high half
   always_ff @(posedge clk_camera) begin
      if (byte_take) begin
         if (phase) begin
            pixel.bytes.lo <= data_s1;
         end else begin
            pixel.bytes.hi <= data_s1;
         end
      end
   end

endmodule

// ==== hdl/camera_consts.svh ====
`ifndef CAMERA_CONSTS_SVH
`define CAMERA_CONSTS_SVH

// one byte per pixel-clock edge from the sensor
`define CAMERA_BYTE_W 8

// two bytes make one rgb565 pixel
`define CAMERA_PIXEL_W 16

// phrase handed to the memory writer
`define CAMERA_PHRASE_PIXELS 8
`define CAMERA_PHRASE_W 128

// coordinate counters
`define CAMERA_HCOUNT_W 13
`define CAMERA_VCOUNT_W 12

// probe measurement word
`define CAMERA_STAT_W 32

// cycles between periodic probe latches
`define CAMERA_TICK_CYCLES 2048

`endif

// ==== hdl/camera_coord.sv ====
`include "camera_consts.svh"

module camera_coord (
   input  logic                        clk_camera,
   input  logic                        rst_in,
   input  logic                        pixel_valid,
   input  logic                        hsync,
   input  logic                        vsync,
   input  camera_pkg::pixel_t          pixel,
   output logic                        coord_valid,
   output camera_pkg::pixel_t          coord_pixel,
   output logic [`CAMERA_HCOUNT_W-1:0] hcount,
   output logic [`CAMERA_VCOUNT_W-1:0] vcount
);

   // position the next pixel will take
   logic [`CAMERA_HCOUNT_W-1:0] col;
   logic [`CAMERA_VCOUNT_W-1:0] row;

   logic hsync_prev;
   logic hsync_fall;

   assign hsync_fall = hsync_prev && !hsync;

   always_ff @(posedge clk_camera) begin
      if (rst_in) begin
         coord_valid <= 1'b0;
         hsync_prev  <= 1'b0;
         col         <= '0;
         row         <= '0;
         hcount      <= '0;
         vcount      <= '0;
      end else begin
         coord_valid <= pixel_valid;
         hsync_prev  <= hsync;
         if (vsync) begin
            // frame blanking holds everything at the origin
            col    <= '0;
            row    <= '0;
            hcount <= '0;
            vcount <= '0;
         end else if (hsync_fall) begin
            col    <= '0;
            row    <= row + 1'b1;
            hcount <= '0;
            vcount <= row + 1'b1;
         end else if (pixel_valid) begin
            col    <= col + 1'b1;
            hcount <= col;
            vcount <= row;
         end
      end
   end

   // pixel travels with its coordinates
   always_ff @(posedge clk_camera) begin
      if (pixel_valid) begin
         coord_pixel <= pixel;
      end
   end

endmodule

// ==== hdl/camera_pkg.sv ====
`include "camera_consts.svh"

package camera_pkg;

   // byte view, in arrival order from the camera
   typedef struct packed {
      logic [`CAMERA_BYTE_W-1:0] hi;
      logic [`CAMERA_BYTE_W-1:0] lo;
   } pixel_bytes_t;

   // rgb565 view of the same word
   typedef struct packed {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
   } pixel_rgb_t;

   typedef union packed {
      pixel_bytes_t bytes;
      pixel_rgb_t   rgb;
   } pixel_t;

   // probe measurement select, driven from two switches
   typedef enum logic [1:0] {
      sel_coord       = 2'b00,
      sel_frame_bytes = 2'b01,
      sel_frame_lines = 2'b10,
      sel_line_bytes  = 2'b11
   } stat_sel_t;

endpackage

// ==== hdl/camera_top.sv ====
`include "camera_consts.svh"

module camera_top (
   input  logic                        clk_camera,
   input  logic                        rst_in,
   input  logic [`CAMERA_BYTE_W-1:0]   cam_data,
   input  logic                        cam_pclk,
   input  logic                        cam_hsync,
   input  logic                        cam_vsync,
   input  logic                        phrase_ready,
   input  camera_pkg::stat_sel_t       stat_sel,
   input  logic                        refresh,
   output logic                        phrase_valid,
   output logic [`CAMERA_PHRASE_W-1:0] phrase_data,
   output logic [`CAMERA_STAT_W-1:0]   display,
   output logic                        stale,
   output logic                        heartbeat
);

   // capture outputs
   logic               hsync;
   logic               vsync;
   logic               byte_valid;
   logic               pixel_valid;
   camera_pkg::pixel_t pixel;

   // coordinate stage outputs
   logic                        coord_valid;
   camera_pkg::pixel_t          coord_pixel;
   logic [`CAMERA_HCOUNT_W-1:0] hcount;
   logic [`CAMERA_VCOUNT_W-1:0] vcount;

   camera_capture u_camera_capture (
      .clk_camera  (clk_camera),
      .rst_in      (rst_in),
      .cam_data    (cam_data),
      .cam_pclk    (cam_pclk),
      .cam_hsync   (cam_hsync),
      .cam_vsync   (cam_vsync),
      .hsync       (hsync),
      .vsync       (vsync),
      .byte_valid  (byte_valid),
      .pixel_valid (pixel_valid),
      .pixel       (pixel)
   );

   camera_coord u_camera_coord (
      .clk_camera  (clk_camera),
      .rst_in      (rst_in),
      .pixel_valid (pixel_valid),
      .hsync       (hsync),
      .vsync       (vsync),
      .pixel       (pixel),
      .coord_valid (coord_valid),
      .coord_pixel (coord_pixel),
      .hcount      (hcount),
      .vcount      (vcount)
   );

   phrase_builder u_phrase_builder (
      .clk_camera   (clk_camera),
      .rst_in       (rst_in),
      .coord_valid  (coord_valid),
      .coord_pixel  (coord_pixel),
      .phrase_ready (phrase_ready),
      .phrase_valid (phrase_valid),
      .phrase_data  (phrase_data)
   );

   frame_stats u_frame_stats (
      .clk_camera  (clk_camera),
      .rst_in      (rst_in),
      .byte_valid  (byte_valid),
      .hsync       (hsync),
      .vsync       (vsync),
      .hcount      (hcount),
      .vcount      (vcount),
      .coord_pixel (coord_pixel),
      .stat_sel    (stat_sel),
      .refresh     (refresh),
      .display     (display),
      .stale       (stale),
      .heartbeat   (heartbeat)
   );

endmodule

// ==== hdl/frame_stats.sv ====
`include "camera_consts.svh"

module frame_stats (
   input  logic                        clk_camera,
   input  logic                        rst_in,
   input  logic                        byte_valid,
   input  logic                        hsync,
   input  logic                        vsync,
   input  logic [`CAMERA_HCOUNT_W-1:0] hcount,
   input  logic [`CAMERA_VCOUNT_W-1:0] vcount,
   input  camera_pkg::pixel_t          coord_pixel,
   input  camera_pkg::stat_sel_t       stat_sel,
   input  logic                        refresh,
   output logic [`CAMERA_STAT_W-1:0]   display,
   output logic                        stale,
   output logic                        heartbeat
);

   localparam int TICK_W = $clog2(`CAMERA_TICK_CYCLES);
   localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`CAMERA_TICK_CYCLES - 1);
   localparam int HALF_W = `CAMERA_STAT_W / 2;
   localparam int V_PAD = HALF_W - `CAMERA_VCOUNT_W;
   localparam int H_PAD = HALF_W - `CAMERA_HCOUNT_W;

   logic hsync_prev;
   logic vsync_prev;
   logic hsync_fall;
   logic vsync_rise;

   // running counters
   logic [`CAMERA_STAT_W-1:0] frame_byte_cnt;
   logic [`CAMERA_STAT_W-1:0] frame_line_cnt;
   logic [`CAMERA_STAT_W-1:0] line_byte_cnt;

   // captured measurements
   logic [`CAMERA_STAT_W-1:0] frame_bytes;
   logic [`CAMERA_STAT_W-1:0] frame_lines;
   logic [`CAMERA_STAT_W-1:0] line_bytes;
   logic [`CAMERA_STAT_W-1:0] coord_word;
   logic [`CAMERA_STAT_W-1:0] live;

   logic [TICK_W-1:0] tick_cnt;
   logic              tick;

   assign hsync_fall = hsync_prev && !hsync;
   assign vsync_rise = vsync && !vsync_prev;

   always_ff @(posedge clk_camera) begin
      if (rst_in) begin
         hsync_prev     <= 1'b0;
         vsync_prev     <= 1'b0;
         frame_byte_cnt <= '0;
         frame_line_cnt <= '0;
         line_byte_cnt  <= '0;
         frame_bytes    <= '0;
         frame_lines    <= '0;
         line_bytes     <= '0;
      end else begin
         hsync_prev <= hsync;
         vsync_prev <= vsync;
         if (vsync_rise) begin
            // count anything landing on the edge cycle itself
            frame_bytes    <= frame_byte_cnt + `CAMERA_STAT_W'(byte_valid);
            frame_lines    <= frame_line_cnt + `CAMERA_STAT_W'(hsync_fall);
            frame_byte_cnt <= '0;
            frame_line_cnt <= '0;
         end else begin
            if (byte_valid) begin
               frame_byte_cnt <= frame_byte_cnt + 1'b1;
            end
            if (hsync_fall) begin
               frame_line_cnt <= frame_line_cnt + 1'b1;
            end
         end
         if (hsync_fall) begin
            line_bytes    <= line_byte_cnt;
            line_byte_cnt <= '0;
         end else if (byte_valid) begin
            line_byte_cnt <= line_byte_cnt + 1'b1;
         end
      end
   end

   // free-running tick, first one a full period after reset
   always_ff @(posedge clk_camera) begin
      if (rst_in) begin
         tick_cnt <= '0;
      end else begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   assign tick = (tick_cnt == TICK_LAST);

   // row and column in the halves, spare bits tag the pixel colour
   assign coord_word = {coord_pixel.rgb.red[V_PAD-1:0], vcount,
                        coord_pixel.rgb.blue[H_PAD-1:0], hcount};

   always_comb begin
      case (stat_sel)
         camera_pkg::sel_coord:       live = coord_word;
         camera_pkg::sel_frame_bytes: live = frame_bytes;
         camera_pkg::sel_frame_lines: live = frame_lines;
         default:                     live = line_bytes;
      endcase
   end

   always_ff @(posedge clk_camera) begin
      if (rst_in) begin
         display   <= '0;
         stale     <= 1'b0;
         heartbeat <= 1'b0;
      end else if (tick || refresh) begin
         display   <= live;
         heartbeat <= !heartbeat;
         stale     <= 1'b0;
      end else if (display != live) begin
         stale <= 1'b1;
      end
   end

endmodule

// ==== hdl/phrase_builder.sv ====
`include "camera_consts.svh"

module phrase_builder (
   input  logic                        clk_camera,
   input  logic                        rst_in,
   input  logic                        coord_valid,
   input  camera_pkg::pixel_t          coord_pixel,
   input  logic                        phrase_ready,
   output logic                        phrase_valid,
   output logic [`CAMERA_PHRASE_W-1:0] phrase_data
);

   localparam int SLOT_W = $clog2(`CAMERA_PHRASE_PIXELS);
   localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`CAMERA_PHRASE_PIXELS - 1);

   logic [SLOT_W-1:0]           slot;
   logic [`CAMERA_PHRASE_W-1:0] shreg;
   logic                        accept;

   // camera cannot stall, so pixels arriving while a phrase is held are lost
   assign accept = coord_valid && !phrase_valid;

   always_ff @(posedge clk_camera) begin
      if (rst_in) begin
         slot         <= '0;
         phrase_valid <= 1'b0;
      end else begin
         if (accept) begin
            slot <= slot + 1'b1;
            if (slot == LAST_SLOT) begin
               slot         <= '0;
               phrase_valid <= 1'b1;
            end
         end else if (phrase_valid && phrase_ready) begin
            phrase_valid <= 1'b0;
         end
      end
   end

   // new pixel enters at the top, so the first of a group ends up in the lowest bits
   always_ff @(posedge clk_camera) begin
      if (accept) begin
         shreg <= {coord_pixel, shreg[`CAMERA_PHRASE_W-1:`CAMERA_PIXEL_W]};
      end
   end

   // register only shifts while no phrase is held, so it stays stable until transfer
   assign phrase_data = shreg;

endmodule

// ==== src.f ====
+incdir+hdl
hdl/camera_pkg.sv
hdl/camera_capture.sv
hdl/camera_coord.sv
hdl/phrase_builder.sv
hdl/frame_stats.sv
hdl/camera_top.sv
verification/camera_sensor.sv
verification/camera_tb.sv

// ==== verification/camera_sensor.sv ====
`include "camera_consts.svh"

module camera_sensor #(
   parameter int FRAMES   = 3,
   parameter int LINES    = 4,
   parameter int MIN_PIX  = 24,
   parameter int MAX_PIX  = 40,
   parameter int LINE_GAP = 4,
   parameter int BLANK    = 6
) (
   input  logic                      clk_camera,
   input  logic                      rst_in,
   output logic [`CAMERA_BYTE_W-1:0] cam_data,
   output logic                      cam_pclk,
   output logic                      cam_hsync,
   output logic                      cam_vsync,
   output logic                      phrase_ready,
   output logic                      ordered,
   output logic                      sent_valid,
   output camera_pkg::pixel_t        sent_pixel,
   output logic [`CAMERA_STAT_W-1:0] last_line_bytes,
   output logic [`CAMERA_STAT_W-1:0] last_frame_bytes,
   output logic [`CAMERA_STAT_W-1:0] last_frame_lines,
   output logic                      done
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [31:0] rng_state;
   logic        backpressure;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // one clk_camera cycle, ready redrawn every cycle under back-pressure
   task automatic next_cycle();
      @(negedge clk_camera);
      sent_valid = 1'b0;
      if (backpressure) begin
         rng_state    = xorshift32(rng_state);
         phrase_ready = (rng_state[1:0] != 2'b00);
      end else begin
         phrase_ready = 1'b1;
      end
   endtask

   // data changes with pclk low, so it is settled at the rising edge
   task automatic pclk_period(input logic [7:0] data, input logic hs, input logic vs);
      next_cycle();
      cam_pclk  = 1'b0;
      cam_data  = data;
      cam_hsync = hs;
      cam_vsync = vs;
      next_cycle();
      next_cycle();
      cam_pclk = 1'b1;
      next_cycle();
   endtask

   task automatic send_line(output int nbytes);
      int                 npix;
      camera_pkg::pixel_t px;
      rng_state = xorshift32(rng_state);
      npix = MIN_PIX + int'(rng_state % (MAX_PIX - MIN_PIX + 1));
      for (int i = 0; i < npix; i++) begin
         rng_state = xorshift32(rng_state);
         px = rng_state[15:0];
         // first byte on the wire is the high half
         pclk_period(px.bytes.hi, 1'b1, 1'b0);
         pclk_period(px.bytes.lo, 1'b1, 1'b0);
         sent_valid = 1'b1;
         sent_pixel = px;
      end
      repeat (LINE_GAP) pclk_period(8'h00, 1'b0, 1'b0);
      nbytes = 2 * npix;
   endtask

   task automatic send_blanking();
      repeat (BLANK) pclk_period(8'h00, 1'b0, 1'b1);
      repeat (2) pclk_period(8'h00, 1'b0, 1'b0);
   endtask

   initial begin
      int line_bytes;
      int frame_bytes;
      rng_state        = 32'h3ed9_7607;
      backpressure     = 1'b0;
      ordered          = 1'b1;
      cam_data         = '0;
      cam_pclk         = 1'b0;
      cam_hsync        = 1'b0;
      cam_vsync        = 1'b0;
      phrase_ready     = 1'b1;
      sent_valid       = 1'b0;
      sent_pixel       = '0;
      last_line_bytes  = '0;
      last_frame_bytes = '0;
      last_frame_lines = '0;
      done             = 1'b0;
      @(posedge clk_camera);
      while (rst_in) @(posedge clk_camera);
      for (int f = 0; f < FRAMES; f++) begin
         // first frame runs with ready high, later ones back-pressured
         if (f == 1) begin
            backpressure = 1'b1;
            ordered      = 1'b0;
         end
         send_blanking();
         frame_bytes = 0;
         for (int l = 0; l < LINES; l++) begin
            send_line(line_bytes);
            frame_bytes     = frame_bytes + line_bytes;
            last_line_bytes = line_bytes;
         end
         last_frame_bytes = frame_bytes;
         last_frame_lines = LINES;
      end
      // vsync rise closes the last frame
      backpressure = 1'b0;
      repeat (BLANK) pclk_period(8'h00, 1'b0, 1'b1);
      done = 1'b1;
   end

endmodule

// ==== verification/camera_tb.sv ====
`include "camera_consts.svh"

module camera_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int FRAMES      = 3;
   localparam int LINES       = 4;
   localparam int MIN_PIX     = 24;
   localparam int MAX_PIX     = 40;
   localparam int LINE_GAP    = 4;
   localparam int BLANK       = 6;
   localparam int PCLK_CYCLES = 4;
   localparam int GROUP       = `CAMERA_PHRASE_PIXELS;
   localparam int PIX_W       = `CAMERA_PIXEL_W;
   // worst-case frame length in clk_camera cycles
   localparam int FRAME_CYCLES =
      PCLK_CYCLES * (LINES * (2 * MAX_PIX + LINE_GAP) + BLANK + 2);
   // frames plus closing blanking, wait for a tick, then the probe tests
   localparam int CYCLE_LIMIT =
      16 + (FRAMES + 1) * FRAME_CYCLES + 2 * `CAMERA_TICK_CYCLES + 200;

   logic                        clk_camera = 1'b0;
   logic                        rst_in;
   logic [`CAMERA_BYTE_W-1:0]   cam_data;
   logic                        cam_pclk;
   logic                        cam_hsync;
   logic                        cam_vsync;
   logic                        phrase_ready;
   camera_pkg::stat_sel_t       stat_sel;
   logic                        refresh;
   logic                        phrase_valid;
   logic [`CAMERA_PHRASE_W-1:0] phrase_data;
   logic [`CAMERA_STAT_W-1:0]   display;
   logic                        stale;
   logic                        heartbeat;

   // model side
   logic                      ordered;
   logic                      sent_valid;
   camera_pkg::pixel_t        sent_pixel;
   logic [`CAMERA_STAT_W-1:0] last_line_bytes;
   logic [`CAMERA_STAT_W-1:0] last_frame_bytes;
   logic [`CAMERA_STAT_W-1:0] last_frame_lines;
   logic                      done;

   logic [PIX_W-1:0] pix_q[$];
   int               next_idx       = 0;
   int               errors         = 0;
   int               cycles         = 0;
   int               ordered_count  = 0;
   int               pressure_count = 0;

   camera_top u_camera_top (
      .clk_camera   (clk_camera),
      .rst_in       (rst_in),
      .cam_data     (cam_data),
      .cam_pclk     (cam_pclk),
      .cam_hsync    (cam_hsync),
      .cam_vsync    (cam_vsync),
      .phrase_ready (phrase_ready),
      .stat_sel     (stat_sel),
      .refresh      (refresh),
      .phrase_valid (phrase_valid),
      .phrase_data  (phrase_data),
      .display      (display),
      .stale        (stale),
      .heartbeat    (heartbeat)
   );

   camera_sensor #(
      .FRAMES   (FRAMES),
      .LINES    (LINES),
      .MIN_PIX  (MIN_PIX),
      .MAX_PIX  (MAX_PIX),
      .LINE_GAP (LINE_GAP),
      .BLANK    (BLANK)
   ) u_camera_sensor (
      .clk_camera       (clk_camera),
      .rst_in           (rst_in),
      .cam_data         (cam_data),
      .cam_pclk         (cam_pclk),
      .cam_hsync        (cam_hsync),
      .cam_vsync        (cam_vsync),
      .phrase_ready     (phrase_ready),
      .ordered          (ordered),
      .sent_valid       (sent_valid),
      .sent_pixel       (sent_pixel),
      .last_line_bytes  (last_line_bytes),
      .last_frame_bytes (last_frame_bytes),
      .last_frame_lines (last_frame_lines),
      .done             (done)
   );

   initial begin
      forever #10 clk_camera = ~clk_camera;
   end

   task automatic check_eq(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
      assert (actual === expected) else begin
         errors++;
         $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // eight recorded pixels with the first one in the lowest bits
   function automatic logic [`CAMERA_PHRASE_W-1:0] group_at(input int k);
      logic [`CAMERA_PHRASE_W-1:0] p;
      for (int j = 0; j < GROUP; j++) begin
         p[PIX_W*j +: PIX_W] = pix_q[k+j];
      end
      return p;
   endfunction

   function automatic int find_group(input int from, input logic [`CAMERA_PHRASE_W-1:0] p);
      for (int k = from; k + GROUP <= pix_q.size(); k++) begin
         if (group_at(k) == p) begin
            return k;
         end
      end
      return -1;
   endfunction

   task automatic check_idle_outputs(input string name);
      check_eq({name, "_phrase_valid"}, 1'b0, phrase_valid);
      check_eq({name, "_stale"}, 1'b0, stale);
      check_eq({name, "_heartbeat"}, 1'b0, heartbeat);
      check_eq({name, "_display"}, '0, display);
   endtask

   task automatic refresh_and_check(input camera_pkg::stat_sel_t sel,
                                    input logic [31:0] expected, input string name);
      logic hb_before;
      @(negedge clk_camera);
      hb_before = heartbeat;
      stat_sel  = sel;
      refresh   = 1'b1;
      @(negedge clk_camera);
      refresh = 1'b0;
      check_eq({name, "_display"}, expected, display);
      check_eq({name, "_heartbeat"}, !hb_before, heartbeat);
      check_eq({name, "_stale"}, 1'b0, stale);
   endtask

   // outputs sampled on the falling edge and ready on the rising edge
   initial begin
      logic                        v;
      logic                        r;
      logic                        held;
      logic [`CAMERA_PHRASE_W-1:0] d;
      logic [`CAMERA_PHRASE_W-1:0] held_data;
      int                          k;
      held      = 1'b0;
      held_data = '0;
      forever begin
         @(negedge clk_camera);
         v = phrase_valid;
         d = phrase_data;
         @(posedge clk_camera);
         r = phrase_ready;
         if (sent_valid) begin
            pix_q.push_back(sent_pixel);
         end
         if (held) begin
            check_eq("test2_hold_valid", 1'b1, v);
            check_eq("test2_hold_data", held_data, d);
         end
         if (v === 1'b1 && r === 1'b1) begin
            if (ordered) begin
               assert (next_idx + GROUP <= pix_q.size()) else begin
                  errors++;
                  $display("phrase transferred before eight pixels were sent");
               end
               if (next_idx + GROUP <= pix_q.size()) begin
                  check_eq("test1_phrase_order", group_at(next_idx), d);
               end
               next_idx = next_idx + GROUP;
               ordered_count++;
            end else begin
               k = find_group(next_idx, d);
               assert (k >= 0) else begin
                  errors++;
                  $display("CHECK FAILED test2_phrase_content: expected %0s, actual %0h",
                           "eight consecutive sent pixels", d);
               end
               if (k >= 0) begin
                  next_idx = k + GROUP;
               end
               pressure_count++;
            end
         end
         held      = (v === 1'b1) && (r !== 1'b1);
         held_data = d;
      end
   end

   initial begin
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk_camera);
         cycles++;
      end
      $display("timeout: run still going after %0d cycles, %0d errors so far",
               CYCLE_LIMIT, errors);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      logic hb;
      rst_in   = 1'b1;
      stat_sel = camera_pkg::sel_frame_bytes;
      refresh  = 1'b0;
      for (int i = 0; i < 16; i++) begin
         @(negedge clk_camera);
         check_idle_outputs("test6_in_reset");
      end
      rst_in = 1'b0;
      repeat (4) begin
         @(negedge clk_camera);
         check_idle_outputs("test6_after_reset");
      end

      while (!done) @(posedge clk_camera);

      // start right after a periodic latch, so the next one is far away
      @(negedge clk_camera);
      hb = heartbeat;
      while (heartbeat == hb) @(negedge clk_camera);

      refresh_and_check(camera_pkg::sel_frame_bytes, last_frame_bytes, "test3_frame_bytes");
      refresh_and_check(camera_pkg::sel_frame_lines, last_frame_lines, "test4_frame_lines");
      refresh_and_check(camera_pkg::sel_line_bytes, last_line_bytes, "test4_line_bytes");

      @(negedge clk_camera);
      stat_sel = camera_pkg::sel_frame_bytes;
      @(negedge clk_camera);
      check_eq("test5_stale_set", 1'b1, stale);
      refresh_and_check(camera_pkg::sel_frame_bytes, last_frame_bytes, "test5_stale_clear");

      assert (ordered_count > 0) else begin
         errors++;
         $display("no phrase was transferred while ready was held high");
      end
      assert (pressure_count > 0) else begin
         errors++;
         $display("no phrase was transferred under back-pressure");
      end

      $display("summary: %0d errors, %0d phrases in order, %0d under back-pressure",
               errors, ordered_count, pressure_count);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
